//--- verilog/rf_pg_consts.svh
// Sizing and timing constants for the power-gated register file subsystem
// Included by the package and by every module that sizes storage or the power chain

`ifndef RF_PG_CONSTS_SVH
`define RF_PG_CONSTS_SVH

// ------------------------------
// Array geometry
// ------------------------------
`define RF_PG_BANK_DEPTH 32
`define RF_PG_ADDR_W     5
`define RF_PG_DATA_W     14

// Power switch delay of one bank, in rclk cycles
`define RF_PG_CHAIN_DLY  4

`endif

//--- verilog/rf_pg_pkg.sv
// Shared types of the register file subsystem
// Modules refer to these by scoped name and take the widths from the constants header

`default_nettype none

`include "rf_pg_consts.svh"

package rf_pg_pkg;

    // One stored word and the address of a word inside one bank
    typedef logic [`RF_PG_DATA_W-1:0] rf_word_t;
    typedef logic [`RF_PG_ADDR_W-1:0] rf_addr_t;

    // The top bit of a subsystem address picks bank 0 or bank 1
    typedef logic [`RF_PG_ADDR_W:0] rf_sub_addr_t;

    // Power-gate sequencer states
    typedef enum logic [2:0] {
        PG_UP_WAIT   = 3'd0,
        PG_READY     = 3'd1,
        PG_ISOLATE   = 3'd2,
        PG_DOWN_WAIT = 3'd3,
        PG_OFF       = 3'd4
    } pg_state_t;

endpackage

`default_nettype wire

//--- verilog/mem_reset_sync.sv
// Carries the write-domain reset into the read clock domain
// Two flops deep, so both assertion and release take two rclk edges

`timescale 1ns/1ps
`default_nettype none

module mem_reset_sync (
     input  logic rclk
    ,input  logic rst
    ,output logic rst_sync
);

    // ------------------------------
    // Synchronizer chain
    // ------------------------------

    // First stage may go metastable, the second one settles it
    logic rst_meta;
    logic rst_q;

    // Both stages follow rst one rclk edge apart
    always_ff @(posedge rclk) begin
        rst_meta <= rst;
        rst_q    <= rst_meta;
    end

    // Only the second stage leaves the block
    assign rst_sync = rst_q;

endmodule

`default_nettype wire

//--- verilog/rf_array_2p.sv
// Behavioural model of one 32x14 two-port register file array with power gating
// Write port on wclk, registered read port on rclk, isolation and a power switch chain
// Contents are lost whenever the array is powered off

`timescale 1ns/1ps
`default_nettype none

`include "rf_pg_consts.svh"

module rf_array_2p (
     input  logic                wclk
    ,input  logic                rst
    ,input  logic                we
    ,input  rf_pg_pkg::rf_addr_t waddr
    ,input  rf_pg_pkg::rf_word_t wdata

    ,input  logic                rclk
    ,input  logic                rst_rd
    ,input  logic                re
    ,input  rf_pg_pkg::rf_addr_t raddr
    ,output rf_pg_pkg::rf_word_t rdata

    ,input  logic                isol_en
    ,input  logic                pwr_enable_b_in
    ,output logic                pwr_enable_b_out
);

    rf_pg_pkg::rf_word_t mem [`RF_PG_BANK_DEPTH];
    rf_pg_pkg::rf_word_t rdata_q;

    // Power switch delay line with one bit per rclk cycle of switch latency
    logic [`RF_PG_CHAIN_DLY-1:0] pwr_sr;
    logic                        pwr_off;
    // Powered-off state seen from the write clock
    logic                        pwr_off_meta;
    logic                        pwr_off_w;

    // ------------------------------
    // Power switch model
    // ------------------------------

    // Comes out of reset switched off, so the sequencer has to walk the chain up
    always_ff @(posedge rclk) begin
        if (rst_rd) begin
            pwr_sr <= '1;
        end else begin
            pwr_sr <= {pwr_sr[`RF_PG_CHAIN_DLY-2:0], pwr_enable_b_in};
        end
    end

    // The last stage is both the local supply state and the enable handed down the chain
    assign pwr_off          = pwr_sr[`RF_PG_CHAIN_DLY-1];
    assign pwr_enable_b_out = pwr_sr[`RF_PG_CHAIN_DLY-1];

    // Move the supply state over to wclk before it touches the storage
    always_ff @(posedge wclk) begin
        if (rst) begin
            pwr_off_meta <= 1'b1;
            pwr_off_w    <= 1'b1;
        end else begin
            pwr_off_meta <= pwr_off;
            pwr_off_w    <= pwr_off_meta;
        end
    end

    // ------------------------------
    // Write port
    // ------------------------------

    // No supply means no retention and every entry drops to zero
    // Writes only land while powered and not isolated
    always_ff @(posedge wclk) begin
        if (pwr_off_w) begin
            for (int i = 0; i < `RF_PG_BANK_DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else if (we && !isol_en) begin
            mem[waddr] <= wdata;
        end
    end

    // The read output register holds its word while re is low
    always_ff @(posedge rclk) begin
        if (pwr_off) begin
            rdata_q <= '0;
        end else if (re) begin
            rdata_q <= mem[raddr];
        end
    end

    // Isolation clamps the output to zero
    assign rdata = isol_en ? '0 : rdata_q;

endmodule

`default_nettype wire

//--- verilog/rf_pg_32x14.sv
// Wrapper around one 32x14 power-gated array
// Brings the reset into the read clock domain and passes the functional and power pins through
// Instantiated once per bank by the subsystem top

`timescale 1ns/1ps
`default_nettype none

module rf_pg_32x14 (
     input  logic                wclk
    ,input  logic                rst
    ,input  logic                we
    ,input  rf_pg_pkg::rf_addr_t waddr
    ,input  rf_pg_pkg::rf_word_t wdata

    ,input  logic                rclk
    ,input  logic                re
    ,input  rf_pg_pkg::rf_addr_t raddr
    ,output rf_pg_pkg::rf_word_t rdata

    // Power control and the daisy-chained enable
    ,input  logic                isol_en
    ,input  logic                pwr_enable_b_in
    ,output logic                pwr_enable_b_out
);

    logic rst_rd;

    // Reset for the read-side state of the array
    mem_reset_sync i_rst_rd_sync (
         .rclk     (rclk)
        ,.rst      (rst)
        ,.rst_sync (rst_rd)
    );

    // ------------------------------
    // Storage array
    // ------------------------------
    rf_array_2p i_rf (
         .wclk             (wclk)
        ,.rst              (rst)
        ,.we               (we)
        ,.waddr            (waddr)
        ,.wdata            (wdata)
        ,.rclk             (rclk)
        ,.rst_rd           (rst_rd)
        ,.re               (re)
        ,.raddr            (raddr)
        ,.rdata            (rdata)
        ,.isol_en          (isol_en)
        ,.pwr_enable_b_in  (pwr_enable_b_in)
        ,.pwr_enable_b_out (pwr_enable_b_out)
    );

endmodule

`default_nettype wire

//--- verilog/rf_pg_ctrl.sv
// Power-gate sequencer for a chain of register file banks
// Isolates before removing power, restores power before releasing isolation
// Completion is taken from the chain tail only, so any chain length works

`timescale 1ns/1ps
`default_nettype none

module rf_pg_ctrl (
     input  logic rclk
    ,input  logic rst
    ,input  logic pg_req
    ,input  logic chain_tail_b
    ,output logic isol_en
    ,output logic pwr_enable_b
    ,output logic pg_ready
    ,output logic pg_off
);

    logic                  rst_sync;
    logic                  tail_q;
    rf_pg_pkg::pg_state_t  state_q;
    rf_pg_pkg::pg_state_t  state_nxt;

    // Sequencer runs on the read clock, so it needs the reset there too
    mem_reset_sync i_rst_sync (
         .rclk     (rclk)
        ,.rst      (rst)
        ,.rst_sync (rst_sync)
    );

    // ------------------------------
    // Chain tail sample and state
    // ------------------------------

    // The chain starts switched off, so the tail sample does as well
    always_ff @(posedge rclk) begin
        if (rst_sync) begin
            tail_q  <= 1'b1;
            state_q <= rf_pg_pkg::PG_UP_WAIT;
        end else begin
            tail_q  <= chain_tail_b;
            state_q <= state_nxt;
        end
    end

    // A request is only looked at in READY and OFF
    // Changes during a sequence wait until it has finished
    always_comb begin
        state_nxt = state_q;
        case (state_q)
            rf_pg_pkg::PG_UP_WAIT: begin
                if (!tail_q) state_nxt = rf_pg_pkg::PG_READY;
            end
            rf_pg_pkg::PG_READY: begin
                if (pg_req) state_nxt = rf_pg_pkg::PG_ISOLATE;
            end
            // Isolation gets one full cycle before supply is pulled
            rf_pg_pkg::PG_ISOLATE: begin
                state_nxt = rf_pg_pkg::PG_DOWN_WAIT;
            end
            rf_pg_pkg::PG_DOWN_WAIT: begin
                if (tail_q) state_nxt = rf_pg_pkg::PG_OFF;
            end
            rf_pg_pkg::PG_OFF: begin
                if (!pg_req) state_nxt = rf_pg_pkg::PG_UP_WAIT;
            end
            default: begin
                state_nxt = rf_pg_pkg::PG_UP_WAIT;
            end
        endcase
    end

    // ------------------------------
    // Outputs decoded from state
    // ------------------------------
    assign isol_en      = (state_q != rf_pg_pkg::PG_READY);
    // Supply is requested in every state except the two on the way down
    assign pwr_enable_b = (state_q == rf_pg_pkg::PG_DOWN_WAIT) ||
                          (state_q == rf_pg_pkg::PG_OFF);
    assign pg_ready     = (state_q == rf_pg_pkg::PG_READY);
    assign pg_off       = (state_q == rf_pg_pkg::PG_OFF);

endmodule

`default_nettype wire

//--- verilog/rf_pg_subsys.sv
// Top of the power-gated register file subsystem
// Two 32-entry banks form one 64-entry memory, the address top bit picks the bank
// Both banks share isolation and sit in one power-enable chain behind the sequencer

`timescale 1ns/1ps
`default_nettype none

`include "rf_pg_consts.svh"

module rf_pg_subsys (
     input  logic                    wclk
    ,input  logic                    rclk
    ,input  logic                    rst
    ,input  logic                    we
    ,input  rf_pg_pkg::rf_sub_addr_t waddr
    ,input  rf_pg_pkg::rf_word_t     wdata
    ,input  logic                    re
    ,input  rf_pg_pkg::rf_sub_addr_t raddr
    ,output rf_pg_pkg::rf_word_t     rdata
    ,input  logic                    pg_req
    ,output logic                    pg_ready
    ,output logic                    pg_off
);

    logic                we_b0, we_b1, re_b0, re_b1;
    logic                rsel_q;
    logic                isol_en, pwr_en_b_head, pwr_en_b_mid, chain_tail_b;
    rf_pg_pkg::rf_word_t rdata_b0, rdata_b1;

    // ------------------------------
    // Bank steering
    // ------------------------------
    assign we_b0 = we & ~waddr[`RF_PG_ADDR_W];
    assign we_b1 = we &  waddr[`RF_PG_ADDR_W];
    assign re_b0 = re & ~raddr[`RF_PG_ADDR_W];
    assign re_b1 = re &  raddr[`RF_PG_ADDR_W];

    // Bank select moves on the same edge as the array output register
    always_ff @(posedge rclk) begin
        if (re) rsel_q <= raddr[`RF_PG_ADDR_W];
    end

    assign rdata = rsel_q ? rdata_b1 : rdata_b0;

    // Bank 0 is the head of the power chain, bank 1 the tail
    rf_pg_32x14 i_bank0 (
         .wclk (wclk), .rst (rst), .we (we_b0)
        ,.waddr (waddr[`RF_PG_ADDR_W-1:0]), .wdata (wdata)
        ,.rclk (rclk), .re (re_b0), .raddr (raddr[`RF_PG_ADDR_W-1:0]), .rdata (rdata_b0)
        ,.isol_en (isol_en), .pwr_enable_b_in (pwr_en_b_head)
        ,.pwr_enable_b_out (pwr_en_b_mid)
    );

    rf_pg_32x14 i_bank1 (
         .wclk (wclk), .rst (rst), .we (we_b1)
        ,.waddr (waddr[`RF_PG_ADDR_W-1:0]), .wdata (wdata)
        ,.rclk (rclk), .re (re_b1), .raddr (raddr[`RF_PG_ADDR_W-1:0]), .rdata (rdata_b1)
        ,.isol_en (isol_en), .pwr_enable_b_in (pwr_en_b_mid)
        ,.pwr_enable_b_out (chain_tail_b)
    );

    // ------------------------------
    // Power-gate sequencer
    // ------------------------------
    rf_pg_ctrl i_rf_pg_ctrl (
         .rclk         (rclk)
        ,.rst          (rst)
        ,.pg_req       (pg_req)
        ,.chain_tail_b (chain_tail_b)
        ,.isol_en      (isol_en)
        ,.pwr_enable_b (pwr_en_b_head)
        ,.pg_ready     (pg_ready)
        ,.pg_off       (pg_off)
    );

endmodule

`default_nettype wire

//--- verif/tb_clk_gen.sv
// Free-running clock source for the testbench
// Use one instance per clock domain and set START_NS to shift the first rising edge

`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
     parameter int PERIOD_NS = 20
    ,parameter int START_NS  = 0
) (
    output logic clk
);

    // Low for half a period after the start offset, then a steady square wave
    initial begin
        clk = 1'b0;
        #(START_NS);
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

endmodule

`default_nettype wire

//--- verif/tb_rf_pg_subsys.sv
// Testbench for the power-gated register file subsystem
// Runs power-up, full write and read-back, read hold, power-down with isolation,
// and power-up with retention loss; concurrent assertions do the checking

`timescale 1ns/1ps
`default_nettype none

`include "rf_pg_consts.svh"

module tb_rf_pg_subsys;

    localparam int DEPTH          = 2 * `RF_PG_BANK_DEPTH;
    localparam int UP_LIMIT       = 4 * (2 * `RF_PG_CHAIN_DLY + 4);
    localparam int TIMEOUT_CYCLES = 4000;

    logic                    wclk, rclk, rst, we, re, pg_req, pg_ready, pg_off;
    logic                    chk, up_done;
    rf_pg_pkg::rf_sub_addr_t waddr, raddr;
    rf_pg_pkg::rf_word_t     wdata, rdata, exp_rdata;
    rf_pg_pkg::rf_word_t     sb [DEPTH];
    rf_pg_pkg::rf_sub_addr_t addr_q [$];
    integer                  seed;
    int                      err_cnt, err_mark, pass_cnt, fail_cnt, cycle_cnt, up_cycles;

    tb_clk_gen #(.PERIOD_NS(20), .START_NS(0)) i_wclk_gen (.clk(wclk));
    tb_clk_gen #(.PERIOD_NS(20), .START_NS(7)) i_rclk_gen (.clk(rclk));

    rf_pg_subsys i_rf_pg_subsys (
         .wclk (wclk), .rclk (rclk), .rst (rst)
        ,.we (we), .waddr (waddr), .wdata (wdata)
        ,.re (re), .raddr (raddr), .rdata (rdata)
        ,.pg_req (pg_req), .pg_ready (pg_ready), .pg_off (pg_off)
    );

    // ------------------------------
    // Assertions
    // ------------------------------

    // One rclk after a strobe the word must match the scoreboard
    read_data_chk: assert property (@(posedge rclk) disable iff (rst)
        chk |=> (rdata == $past(exp_rdata)))
        else begin
            $display("[ERROR] %0t rdata: expected %h, got %h",
                     $time, $past(exp_rdata), $sampled(rdata));
            err_cnt++;
        end

    // With re low the output register holds, unless power-down starts
    read_hold_chk: assert property (@(posedge rclk) disable iff (rst)
        (!re && pg_ready) |=> (!pg_ready || $stable(rdata)))
        else begin
            $display("[ERROR] %0t rdata: expected %h, got %h",
                     $time, $past(rdata), $sampled(rdata));
            err_cnt++;
        end

    // Not ready means isolated, so the output is clamped
    isol_clamp_chk: assert property (@(posedge rclk) disable iff (rst)
        !pg_ready |-> (rdata == '0))
        else begin
            $display("[ERROR] %0t rdata: expected %h, got %h", $time, 14'h0, $sampled(rdata));
            err_cnt++;
        end

    // pg_off stays low from reset until the first power-up
    pg_off_chk: assert property (@(posedge rclk) disable iff (rst)
        !up_done |-> !pg_off)
        else begin
            $display("[ERROR] %0t pg_off: expected 0, got %b", $time, $sampled(pg_off));
            err_cnt++;
        end

    // ------------------------------
    // Stimulus helpers
    // ------------------------------
    task automatic write_word(input rf_pg_pkg::rf_sub_addr_t addr, input bit track);
        rf_pg_pkg::rf_word_t data;
        data = rf_pg_pkg::rf_word_t'($random(seed));
        @(posedge wclk);
        we    <= 1'b1;
        waddr <= addr;
        wdata <= data;
        // Only writes made while ready are expected to land
        if (track) sb[addr] = data;
    endtask

    task automatic stop_writes(input int n);
        @(posedge wclk);
        we <= 1'b0;
        repeat (n) @(posedge wclk);
    endtask

    // Strobe for one cycle, then one idle cycle that exercises the hold check
    task automatic read_check(input rf_pg_pkg::rf_sub_addr_t addr);
        @(posedge rclk);
        re        <= 1'b1;
        raddr     <= addr;
        exp_rdata <= sb[addr];
        chk       <= 1'b1;
        @(posedge rclk);
        re  <= 1'b0;
        chk <= 1'b0;
    endtask

    task automatic wait_ready(input logic level);
        while (pg_ready !== level) @(negedge rclk);
    endtask

    task automatic finish_test(input string name);
        if (err_cnt == err_mark) begin
            pass_cnt++;
            $display("PASS  %s", name);
        end else begin
            fail_cnt++;
            $display("FAIL  %s (%0d errors)", name, err_cnt - err_mark);
        end
        err_mark = err_cnt;
    endtask

    // Run limit, well above the length of all tests together
    always @(posedge rclk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d rclk cycles", TIMEOUT_CYCLES);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    // ------------------------------
    // Test sequence
    // ------------------------------
    initial begin
        seed = 76;
        {rst, we, re, pg_req, chk, up_done} = 6'b100000;
        {waddr, raddr, wdata, exp_rdata} = '0;
        {err_cnt, err_mark, pass_cnt, fail_cnt, cycle_cnt, up_cycles} = '0;
        for (int i = 0; i < DEPTH; i++) sb[i] = '0;
        repeat (10) @(posedge wclk);
        rst <= 1'b0;

        // Chain of two banks must come up within a generous bound
        while (pg_ready !== 1'b1) begin
            @(negedge rclk);
            up_cycles++;
        end
        up_done = 1'b1;
        assert (up_cycles <= UP_LIMIT)
            else begin
                $display("Power-up took %0d rclk cycles, more than %0d", up_cycles, UP_LIMIT);
                err_cnt++;
            end
        finish_test("power-up after reset");

        // Write side sees the supply state two wclk edges late
        stop_writes(4);
        for (int a = 0; a < DEPTH; a++) write_word(a, 1'b1);
        stop_writes(3);
        for (int a = 0; a < DEPTH; a++) read_check(a);
        repeat (3) @(posedge rclk);
        finish_test("write and read back all 64 addresses");

        // The output must not follow raddr across both banks while re is low
        for (int i = 0; i < 12; i++) begin
            @(posedge rclk);
            raddr <= rf_pg_pkg::rf_sub_addr_t'(i * 11);
        end
        repeat (2) @(posedge rclk);
        finish_test("read data holds while re is low");

        // Power-down with writes that isolation has to drop
        @(posedge rclk);
        pg_req <= 1'b1;
        wait_ready(1'b0);
        for (int i = 0; i < 4; i++) write_word(rf_pg_pkg::rf_sub_addr_t'($random(seed)), 1'b0);
        stop_writes(1);
        while (pg_off !== 1'b1) @(negedge rclk);
        for (int i = 0; i < DEPTH; i++) sb[i] = '0;
        for (int i = 0; i < 4; i++) write_word(rf_pg_pkg::rf_sub_addr_t'($random(seed)), 1'b0);
        stop_writes(2);
        finish_test("isolation and power-down");

        // Power back up and expect lost contents before fresh data reads back
        @(posedge rclk);
        pg_req <= 1'b0;
        // Bank 0 gets supply while isolation still holds for two switch delays
        // None of these writes may land
        for (int i = 0; i < 2 * `RF_PG_CHAIN_DLY; i++) write_word(i, 1'b0);
        stop_writes(1);
        wait_ready(1'b1);
        for (int a = 0; a < DEPTH; a++) read_check(a);
        stop_writes(4);
        for (int i = 0; i < 8; i++) begin
            addr_q.push_back(rf_pg_pkg::rf_sub_addr_t'($random(seed)));
            write_word(addr_q[i], 1'b1);
        end
        stop_writes(3);
        foreach (addr_q[i]) read_check(addr_q[i]);
        repeat (3) @(posedge rclk);
        finish_test("power-up loses contents, fresh write reads back");

        $display("Tests passed: %0d, tests failed: %0d, errors: %0d", pass_cnt, fail_cnt, err_cnt);
        if (fail_cnt == 0 && err_cnt == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- rf_pg_subsys.f
+incdir+verilog
verilog/rf_pg_pkg.sv
verilog/mem_reset_sync.sv
verilog/rf_array_2p.sv
verilog/rf_pg_32x14.sv
verilog/rf_pg_ctrl.sv
verilog/rf_pg_subsys.sv
verif/tb_clk_gen.sv
verif/tb_rf_pg_subsys.sv

//--- Bender.yml
package:
  name: rf_pg_subsys

export_include_dirs:
  - verilog

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/rf_pg_pkg.sv
      - verilog/mem_reset_sync.sv
      - verilog/rf_array_2p.sv
      - verilog/rf_pg_32x14.sv
      - verilog/rf_pg_ctrl.sv
      - verilog/rf_pg_subsys.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - verif/tb_clk_gen.sv
      - verif/tb_rf_pg_subsys.sv
